// File: include/obi_settings.svh
// bus and memory sizing for the load/store OBI port
// data path assumes 32-bit words with 4 byte lanes
// OBI_GNT_STALL of 0 grants in the same cycle as req

`ifndef OBI_SETTINGS_SVH
`define OBI_SETTINGS_SVH

// one word of address and data
`define OBI_ADDR_WIDTH 32
`define OBI_DATA_WIDTH 32

// one enable per byte lane
`define OBI_BE_WIDTH 4

// word depth of the subordinate memory, beyond it is an error
`define OBI_MEM_WORDS 256

// cycles gnt stays low after req rises
`define OBI_GNT_STALL 2

`endif

// File: logic/lsu_align.sv
// lane aligner between the load/store request and the OBI core channel
// address bits unused by the access size are ignored, no misalign check
// only one request in flight, load info is held from acceptance to response

`timescale 1ns/1ps

`include "obi_settings.svh"

module lsu_align (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_valid_i,
    output logic                         req_ready_o,
    input  logic [`OBI_ADDR_WIDTH-1:0]   req_addr_i,
    input  lsu_pkg::lsu_op_e             req_op_i,
    input  lsu_pkg::mem_size_e           req_size_i,
    input  logic                         req_unsigned_i,
    input  logic [`OBI_DATA_WIDTH-1:0]   req_wdata_i,
    input  logic                         resp_ready_i,
    output logic                         resp_valid_o,
    output logic [`OBI_DATA_WIDTH-1:0]   resp_rdata_o,
    output logic                         resp_err_o,
    obi_core_if.lsu                      core
);

    logic [1:0]                   req_off;
    logic                         accept;
    // load info held until the response returns
    lsu_pkg::mem_size_e           size_q;
    logic [1:0]                   off_q;
    logic                         unsigned_q;
    logic [4:0]                   shift;
    logic [`OBI_DATA_WIDTH-1:0]   lane_data;
    logic                         sign_ext;

    assign req_off = req_addr_i[1:0];
    assign accept  = req_valid_i && core.ready;

    // request path, purely combinational
    assign core.valid  = req_valid_i;
    assign req_ready_o = core.ready;
    assign core.addr   = {req_addr_i[`OBI_ADDR_WIDTH-1:2], 2'b00};
    assign core.we     = (req_op_i == lsu_pkg::STORE);

    // byte enables and lane replication of store data
    always_comb begin
        case (req_size_i)
            lsu_pkg::BYTE: begin
                core.be    = 4'b0001 << req_off;
                core.wdata = {4{req_wdata_i[7:0]}};
            end
            lsu_pkg::HALF: begin
                // bit 1 picks the upper or lower half
                core.be    = req_off[1] ? 4'b1100 : 4'b0011;
                core.wdata = {2{req_wdata_i[15:0]}};
            end
            default: begin
                core.be    = 4'b1111;
                core.wdata = req_wdata_i;
            end
        endcase
    end

    // capture size, offset and sign mode on acceptance
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            size_q     <= lsu_pkg::WORD;
            off_q      <= 2'b00;
            unsigned_q <= 1'b0;
        end else if (accept) begin
            size_q     <= req_size_i;
            off_q      <= req_off;
            unsigned_q <= req_unsigned_i;
        end
    end

    // response handshake passes straight through
    assign core.rready  = resp_ready_i;
    assign resp_valid_o = core.rvalid;
    assign resp_err_o   = core.err;

    // move the addressed lane down to bit 0
    always_comb begin
        shift = {off_q, 3'b000};
        if (size_q == lsu_pkg::HALF) begin
            shift = {off_q[1], 4'b0000};
        end
    end

    assign lane_data = core.rdata >> shift;
    assign sign_ext  = !unsigned_q;

    // sign or zero extension by size
    always_comb begin
        case (size_q)
            lsu_pkg::BYTE: resp_rdata_o = {{24{sign_ext & lane_data[7]}}, lane_data[7:0]};
            lsu_pkg::HALF: resp_rdata_o = {{16{sign_ext & lane_data[15]}}, lane_data[15:0]};
            default:       resp_rdata_o = core.rdata;
        endcase
    end

endmodule

// File: logic/lsu_obi_top.sv
// load/store port with OBI memory behind it
// one transaction at a time, resp_valid_o ends each one

`timescale 1ns/1ps

`include "obi_settings.svh"

module lsu_obi_top (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         req_valid_i,
    output logic                         req_ready_o,
    input  logic [`OBI_ADDR_WIDTH-1:0]   req_addr_i,
    input  lsu_pkg::lsu_op_e             req_op_i,
    input  lsu_pkg::mem_size_e           req_size_i,
    input  logic                         req_unsigned_i,
    input  logic [`OBI_DATA_WIDTH-1:0]   req_wdata_i,
    input  logic                         resp_ready_i,
    output logic                         resp_valid_o,
    output logic [`OBI_DATA_WIDTH-1:0]   resp_rdata_o,
    output logic                         resp_err_o
);

    // aligner to controller
    obi_core_if core_if ();
    // controller to memory
    obi_bus_if bus_if ();

    lsu_align lsu_align_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .req_addr_i     (req_addr_i),
        .req_op_i       (req_op_i),
        .req_size_i     (req_size_i),
        .req_unsigned_i (req_unsigned_i),
        .req_wdata_i    (req_wdata_i),
        .resp_ready_i   (resp_ready_i),
        .resp_valid_o   (resp_valid_o),
        .resp_rdata_o   (resp_rdata_o),
        .resp_err_o     (resp_err_o),
        .core           (core_if.lsu)
    );

    obi_controller obi_controller_i (
        .clk   (clk),
        .rst_n (rst_n),
        .core  (core_if.ctrl),
        .bus   (bus_if.manager)
    );

    obi_mem obi_mem_i (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus_if.subordinate)
    );

endmodule

// File: logic/lsu_pkg.sv
// load/store request types seen at the LSU boundary
// misaligned addresses are not detected, unused low bits are ignored

package lsu_pkg;

    // access size of a load or store
    // encoding follows the funct3 low bits of RV32 loads and stores
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } mem_size_e;

    // request direction
    // maps to the bus we bit, store writes
    typedef enum logic {
        LOAD  = 1'b0,
        STORE = 1'b1
    } lsu_op_e;

endpackage

// File: logic/obi_controller.sv
// OBI manager with a single outstanding transaction
// bus rvalid is a one cycle pulse, DUMPING buffers it for a slow consumer
// ready only in IDLE, so no new request while a response is pending

`timescale 1ns/1ps

`include "obi_settings.svh"

module obi_controller (
    input  logic         clk,
    input  logic         rst_n,
    obi_core_if.ctrl     core,
    obi_bus_if.manager   bus
);

    obi_pkg::obi_state_e          state_q;
    obi_pkg::obi_state_e          state_d;

    // captured request fields, replayed while gnt is low
    logic [`OBI_ADDR_WIDTH-1:0]   addr_q;
    logic                         we_q;
    logic [`OBI_BE_WIDTH-1:0]     be_q;
    logic [`OBI_DATA_WIDTH-1:0]   wdata_q;

    // buffered response for DUMPING
    logic [`OBI_DATA_WIDTH-1:0]   rdata_q;
    logic                         err_q;

    logic                         capture_req;
    logic                         capture_resp;

    // fields latched on every accepted request
    assign capture_req  = (state_q == obi_pkg::IDLE) && core.valid;
    // response latched on the rvalid pulse
    assign capture_resp = (state_q == obi_pkg::WAITING) && bus.rvalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= obi_pkg::IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (capture_req) begin
            addr_q  <= core.addr;
            we_q    <= core.we;
            be_q    <= core.be;
            wdata_q <= core.wdata;
        end
        if (capture_resp) begin
            rdata_q <= bus.rdata;
            err_q   <= bus.err;
        end
    end

    always_comb begin
        state_d     = state_q;
        core.ready  = 1'b0;
        core.rvalid = 1'b0;
        core.rdata  = bus.rdata;
        core.err    = bus.err;
        // captured fields by default, IDLE overrides with live ones
        bus.req     = 1'b0;
        bus.addr    = addr_q;
        bus.we      = we_q;
        bus.be      = be_q;
        bus.wdata   = wdata_q;

        case (state_q)
            obi_pkg::IDLE: begin
                core.ready = 1'b1;
                // req follows valid in the same cycle
                bus.req    = core.valid;
                bus.addr   = core.addr;
                bus.we     = core.we;
                bus.be     = core.be;
                bus.wdata  = core.wdata;
                if (core.valid) begin
                    if (bus.gnt) begin
                        state_d = obi_pkg::WAITING;
                    end else begin
                        state_d = obi_pkg::REQUESTING;
                    end
                end
            end
            obi_pkg::REQUESTING: begin
                // req must stay high with stable fields until gnt
                bus.req = 1'b1;
                if (bus.gnt) begin
                    state_d = obi_pkg::WAITING;
                end
            end
            obi_pkg::WAITING: begin
                // forward the pulse directly
                core.rvalid = bus.rvalid;
                if (bus.rvalid) begin
                    if (core.rready) begin
                        state_d = obi_pkg::IDLE;
                    end else begin
                        state_d = obi_pkg::DUMPING;
                    end
                end
            end
            obi_pkg::DUMPING: begin
                // bus pulse is gone, serve from the buffer
                core.rvalid = 1'b1;
                core.rdata  = rdata_q;
                core.err    = err_q;
                if (core.rready) begin
                    state_d = obi_pkg::IDLE;
                end
            end
            default: begin
                state_d = obi_pkg::IDLE;
            end
        endcase
    end

endmodule

// File: logic/obi_if.sv
// core side and bus side OBI signal bundles
// no atop and no rready on the bus side

`timescale 1ns/1ps

`include "obi_settings.svh"

// aligner to controller, request and response channels
interface obi_core_if;
    // request channel, addr is word aligned
    logic                         valid;
    logic                         ready;
    logic [`OBI_ADDR_WIDTH-1:0]   addr;
    logic                         we;
    logic [`OBI_BE_WIDTH-1:0]     be;
    logic [`OBI_DATA_WIDTH-1:0]   wdata;
    // response channel
    logic                         rvalid;
    logic                         rready;
    logic [`OBI_DATA_WIDTH-1:0]   rdata;
    logic                         err;

    modport lsu (output valid, addr, we, be, wdata, rready,
                 input  ready, rvalid, rdata, err);
    modport ctrl (input  valid, addr, we, be, wdata, rready,
                  output ready, rvalid, rdata, err);
endinterface

// controller to memory, plain OBI without rready
interface obi_bus_if;
    logic                         req;
    logic                         gnt;
    logic [`OBI_ADDR_WIDTH-1:0]   addr;
    logic                         we;
    logic [`OBI_BE_WIDTH-1:0]     be;
    logic [`OBI_DATA_WIDTH-1:0]   wdata;
    // rvalid is a single cycle pulse
    logic                         rvalid;
    logic [`OBI_DATA_WIDTH-1:0]   rdata;
    logic                         err;

    modport manager (output req, addr, we, be, wdata,
                     input  gnt, rvalid, rdata, err);
    modport subordinate (input  req, addr, we, be, wdata,
                         output gnt, rvalid, rdata, err);
endinterface

// File: logic/obi_mem.sv
// behavioural OBI subordinate, word array without reset contents
// gnt held low for OBI_GNT_STALL cycles, rvalid one cycle after grant
// word addresses at or beyond OBI_MEM_WORDS answer err and do not write

`timescale 1ns/1ps

`include "obi_settings.svh"

module obi_mem (
    input  logic              clk,
    input  logic              rst_n,
    obi_bus_if.subordinate    bus
);

    localparam int IDX_W = $clog2(`OBI_MEM_WORDS);
    // wide enough to hold the stall value, also when it is 0
    localparam int CNT_W = $clog2(`OBI_GNT_STALL + 2);
    localparam logic [CNT_W-1:0] STALL = `OBI_GNT_STALL;

    logic [`OBI_DATA_WIDTH-1:0]   mem [`OBI_MEM_WORDS];

    logic [CNT_W-1:0]             stall_cnt;
    logic                         grant;
    logic [IDX_W-1:0]             word_idx;
    logic                         in_range;

    // response stage
    logic                         rvalid_q;
    logic [`OBI_DATA_WIDTH-1:0]   rdata_q;
    logic                         err_q;

    assign word_idx = bus.addr[IDX_W+1:2];
    assign in_range = bus.addr[`OBI_ADDR_WIDTH-1:2] < `OBI_MEM_WORDS;

    // gnt once the counter reaches the stall
    assign bus.gnt = bus.req && (stall_cnt == STALL);
    assign grant   = bus.gnt;

    // counts cycles of req without gnt
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            stall_cnt <= '0;
        end else if (!bus.req || grant) begin
            stall_cnt <= '0;
        end else begin
            stall_cnt <= stall_cnt + 1'b1;
        end
    end

    // one cycle response pulse after the grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= grant;
        end
    end

    // data and error captured at the grant
    always_ff @(posedge clk) begin
        if (grant) begin
            err_q <= !in_range;
            if (!bus.we && in_range) begin
                rdata_q <= mem[word_idx];
            end else begin
                // stores and errors return zero
                rdata_q <= '0;
            end
        end
    end

    // lane write, skipped when out of range
    always_ff @(posedge clk) begin
        if (grant && bus.we && in_range) begin
            for (int i = 0; i < `OBI_BE_WIDTH; i++) begin
                if (bus.be[i]) begin
                    mem[word_idx][8*i +: 8] <= bus.wdata[8*i +: 8];
                end
            end
        end
    end

    assign bus.rvalid = rvalid_q;
    assign bus.rdata  = rdata_q;
    assign bus.err    = err_q;

endmodule

// File: logic/obi_pkg.sv
// bus protocol types for the OBI manager side
// one transaction outstanding, no rready on the bus

package obi_pkg;

    // manager FSM states
    // IDLE        accepts a core request, req follows valid
    // REQUESTING  holds captured fields until gnt
    // WAITING     address phase done, waits for rvalid pulse
    // DUMPING     holds the buffered response until rready
    typedef enum logic [1:0] {
        IDLE       = 2'b00,
        REQUESTING = 2'b01,
        WAITING    = 2'b10,
        DUMPING    = 2'b11
    } obi_state_e;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it, pass only on the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module lsu_obi_tb \
    -f sources.f -o lsu_obi_sim

sim_out=$(./obj_dir/lsu_obi_sim 2>&1 || true)
echo "$sim_out"

if grep -q "Verification passed" <<< "$sim_out"; then
    exit 0
fi
exit 1

// File: sources.f
+incdir+include
logic/obi_pkg.sv
logic/lsu_pkg.sv
logic/obi_if.sv
logic/lsu_align.sv
logic/obi_controller.sv
logic/obi_mem.sv
logic/lsu_obi_top.sv
testbench/lsu_obi_tb.sv

// File: testbench/lsu_obi_tb.sv
// directed tests for the load/store OBI port
// memory has no reset contents, every word is written before any read
// expected latency follows OBI_GNT_STALL from the settings header

`timescale 1ns/1ps

`include "obi_settings.svh"

module lsu_obi_tb;

    localparam int WORDS   = `OBI_MEM_WORDS;
    localparam int IDX_W   = $clog2(WORDS);
    localparam int LATENCY = `OBI_GNT_STALL + 1;
    // fill pass, full recheck after the out-of-range store, directed tests
    localparam int NUM_XFERS  = 2 * WORDS + 240;
    localparam int MAX_CYCLES = NUM_XFERS * (`OBI_GNT_STALL + 8) + 100;

    logic                 clk;
    logic                 rst_n;
    logic                 req_valid_i;
    logic                 req_ready_o;
    logic [31:0]          req_addr_i;
    lsu_pkg::lsu_op_e     req_op_i;
    lsu_pkg::mem_size_e   req_size_i;
    logic                 req_unsigned_i;
    logic [31:0]          req_wdata_i;
    logic                 resp_ready_i;
    logic                 resp_valid_o;
    logic [31:0]          resp_rdata_o;
    logic                 resp_err_o;

    // byte image of the memory, little endian
    logic [7:0]           ref_mem [4*WORDS];
    logic [31:0]          lfsr_q = 32'he888;
    int                   cycle_cnt = 0;

    lsu_obi_top lsu_obi_top_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_valid_i    (req_valid_i),
        .req_ready_o    (req_ready_o),
        .req_addr_i     (req_addr_i),
        .req_op_i       (req_op_i),
        .req_size_i     (req_size_i),
        .req_unsigned_i (req_unsigned_i),
        .req_wdata_i    (req_wdata_i),
        .resp_ready_i   (resp_ready_i),
        .resp_valid_o   (resp_valid_o),
        .resp_rdata_o   (resp_rdata_o),
        .resp_err_o     (resp_err_o)
    );

    always #10 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout, tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Verification failed");
            $fatal(1);
        end
    end

    // Galois step, taps x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h8020_0003;
        end
        return s >> 1;
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            r = {r[30:0], lfsr_q[0]};
        end
        return r;
    endfunction

    // word aligned, in range
    function automatic logic [31:0] rand_addr();
        return (rand_bits(IDX_W) % WORDS) << 2;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            abort_run($sformatf("[ERROR] %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        logic [31:0] b;
        b = {addr[31:2], 2'b00};
        return {ref_mem[b+3], ref_mem[b+2], ref_mem[b+1], ref_mem[b]};
    endfunction

    // lanes written by a store of this size
    function automatic void ref_store(input lsu_pkg::mem_size_e size, input logic [31:0] addr,
                                      input logic [31:0] wdata);
        logic [31:0] b;
        case (size)
            lsu_pkg::BYTE: ref_mem[addr] = wdata[7:0];
            lsu_pkg::HALF: begin
                b = {addr[31:1], 1'b0};
                ref_mem[b]   = wdata[7:0];
                ref_mem[b+1] = wdata[15:8];
            end
            default: begin
                b = {addr[31:2], 2'b00};
                for (int i = 0; i < 4; i++) begin
                    ref_mem[b+i] = wdata[8*i +: 8];
                end
            end
        endcase
    endfunction

    // extension rule of RV32 loads
    function automatic logic [31:0] ref_load(input lsu_pkg::mem_size_e size, input logic uns,
                                             input logic [31:0] addr);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_mem[addr];
        h = {ref_mem[{addr[31:1], 1'b1}], ref_mem[{addr[31:1], 1'b0}]};
        case (size)
            lsu_pkg::BYTE: return {{24{!uns & b[7]}}, b};
            lsu_pkg::HALF: return {{16{!uns & h[15]}}, h};
            default:       return ref_word(addr);
        endcase
    endfunction

    task automatic drive_req(input lsu_pkg::lsu_op_e op, input lsu_pkg::mem_size_e size,
                             input logic uns, input logic [31:0] addr,
                             input logic [31:0] wdata);
        req_valid_i    <= 1'b1;
        req_op_i       <= op;
        req_size_i     <= size;
        req_unsigned_i <= uns;
        req_addr_i     <= addr;
        req_wdata_i    <= wdata;
        // accepted on the first edge that sees ready
        do begin
            @(posedge clk);
        end while (!req_ready_o);
        req_valid_i <= 1'b0;
        // inputs change after acceptance, the DUT must work from its own copy
        req_op_i       <= (op == lsu_pkg::STORE) ? lsu_pkg::LOAD : lsu_pkg::STORE;
        req_size_i     <= (size == lsu_pkg::WORD) ? lsu_pkg::BYTE : lsu_pkg::WORD;
        req_unsigned_i <= !uns;
        req_addr_i     <= ~addr;
        req_wdata_i    <= ~wdata;
    endtask

    // one transaction with resp_ready_i high, latency is fixed then
    task automatic xfer(input lsu_pkg::lsu_op_e op, input lsu_pkg::mem_size_e size,
                        input logic uns, input logic [31:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic err);
        int lat;
        lat = 0;
        drive_req(op, size, uns, addr, wdata);
        do begin
            @(posedge clk);
            lat++;
        end while (!(resp_valid_o && resp_ready_i));
        rdata = resp_rdata_o;
        err   = resp_err_o;
        check_value("response latency", lat, LATENCY);
    endtask

    task automatic store_checked(input lsu_pkg::mem_size_e size, input logic [31:0] addr,
                                 input logic [31:0] wdata);
        logic [31:0] rdata;
        logic        err;
        xfer(lsu_pkg::STORE, size, 1'b0, addr, wdata, rdata, err);
        check_value("resp_err_o", err, 1'b0);
        ref_store(size, addr, wdata);
    endtask

    task automatic load_checked(input lsu_pkg::mem_size_e size, input logic uns,
                                input logic [31:0] addr);
        logic [31:0] rdata;
        logic        err;
        xfer(lsu_pkg::LOAD, size, uns, addr, '0, rdata, err);
        check_value("resp_err_o", err, 1'b0);
        check_value("resp_rdata_o", rdata, ref_load(size, uns, addr));
    endtask

    task automatic test_reset();
        // first edge applies the reset
        for (int i = 0; i < 2; i++) begin
            @(posedge clk);
            if (i > 0) begin
                check_value("req_ready_o", req_ready_o, 1'b1);
                check_value("resp_valid_o", resp_valid_o, 1'b0);
            end
        end
        rst_n <= 1'b1;
        repeat (2) begin
            @(posedge clk);
            check_value("req_ready_o", req_ready_o, 1'b1);
            check_value("resp_valid_o", resp_valid_o, 1'b0);
        end
    endtask

    task automatic test_word();
        // fill every word so later reads are defined
        for (int w = 0; w < WORDS; w++) begin
            store_checked(lsu_pkg::WORD, w * 4, rand_bits(32));
        end
        repeat (64) begin
            load_checked(lsu_pkg::WORD, 1'b0, rand_addr());
        end
    endtask

    // neighbouring lanes must survive, seen through a word load
    task automatic test_sub_store();
        lsu_pkg::mem_size_e size;
        logic [31:0]        addr;
        repeat (48) begin
            size = rand_bits(1) ? lsu_pkg::HALF : lsu_pkg::BYTE;
            addr = rand_addr() | rand_bits(2);
            store_checked(size, addr, rand_bits(32));
            load_checked(lsu_pkg::WORD, 1'b0, addr);
        end
    endtask

    task automatic test_sub_load();
        lsu_pkg::mem_size_e size;
        logic               uns;
        repeat (64) begin
            size = rand_bits(1) ? lsu_pkg::HALF : lsu_pkg::BYTE;
            uns  = rand_bits(1);
            load_checked(size, uns, rand_addr() | rand_bits(2));
        end
    endtask

    // response parked in DUMPING while rready is low
    task automatic test_backpressure();
        logic [31:0] addr;
        logic [31:0] held;
        addr = rand_addr() | rand_bits(2);
        resp_ready_i <= 1'b0;
        drive_req(lsu_pkg::LOAD, lsu_pkg::HALF, 1'b0, addr, '0);
        do begin
            @(posedge clk);
        end while (!resp_valid_o);
        held = resp_rdata_o;
        check_value("resp_rdata_o", held, ref_load(lsu_pkg::HALF, 1'b0, addr));
        repeat (5) begin
            @(posedge clk);
            check_value("resp_valid_o", resp_valid_o, 1'b1);
            check_value("resp_rdata_o", resp_rdata_o, held);
            check_value("resp_err_o", resp_err_o, 1'b0);
            check_value("req_ready_o", req_ready_o, 1'b0);
        end
        resp_ready_i <= 1'b1;
        // taken on this edge
        @(posedge clk);
        check_value("resp_valid_o", resp_valid_o, 1'b1);
        @(posedge clk);
        check_value("resp_valid_o", resp_valid_o, 1'b0);
        check_value("req_ready_o", req_ready_o, 1'b1);
    endtask

    task automatic test_out_of_range();
        logic [31:0] addr;
        logic [31:0] rdata;
        logic        err;
        // low index bits alias an in-range word
        addr = (rand_bits(IDX_W) + WORDS) << 2;
        xfer(lsu_pkg::LOAD, lsu_pkg::WORD, 1'b0, addr, '0, rdata, err);
        check_value("resp_err_o", err, 1'b1);
        xfer(lsu_pkg::STORE, lsu_pkg::WORD, 1'b0, addr, rand_bits(32), rdata, err);
        check_value("resp_err_o", err, 1'b1);
        for (int w = 0; w < WORDS; w++) begin
            load_checked(lsu_pkg::WORD, 1'b0, w * 4);
        end
    endtask

    initial begin
        clk            = 1'b0;
        rst_n          = 1'b0;
        req_valid_i    = 1'b0;
        req_addr_i     = '0;
        req_op_i       = lsu_pkg::LOAD;
        req_size_i     = lsu_pkg::WORD;
        req_unsigned_i = 1'b0;
        req_wdata_i    = '0;
        resp_ready_i   = 1'b1;
        test_reset();
        test_word();
        test_sub_store();
        test_sub_load();
        test_backpressure();
        test_out_of_range();
        $display("Verification passed");
        $finish;
    end

endmodule
